/* Bender.yml */
package:
  name: cpuCore

sources:
  - isaPkg.sv
  - corePkg.sv
  - instrDecoder.sv
  - regFile.sv
  - execUnit.sv
  - coreSequencer.sv
  - cpuCore.sv
  - target: test
    files:
      - isaModel.sv
      - clockGen.sv
      - cpuCore_props.sv
      - tb_cpuCore.sv

/* all.f */
isaPkg.sv
corePkg.sv
instrDecoder.sv
regFile.sv
execUnit.sv
coreSequencer.sv
cpuCore.sv
isaModel.sv
clockGen.sv
cpuCore_props.sv
tb_cpuCore.sv

/* clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset_n
);

    localparam time HALF_PERIOD  = 4;   // 8 ns clock
    localparam int  RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

/* corePkg.sv */
package corePkg;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
    localparam int          EXEC_LATENCY = 4;   // Enable to done

    typedef enum logic [2:0] {
        DISPATCH   = 3'd0,
        EXECUTE    = 3'd1,
        MEM_SETUP  = 3'd2,
        MEM_ACCESS = 3'd3,
        COMMIT     = 3'd4,
        NEXT_PC    = 3'd5,
        LATCH_INSN = 3'd6
    } seqState_t;

    typedef struct packed {
        isaPkg::opcode_t op;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
    } execOperands_t;

    typedef struct packed {
        logic        strobe;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dataReq_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  idx;
        logic [31:0] value;
    } regWrite_t;

endpackage

/* coreSequencer.sv */
`timescale 1ns/1ps

module coreSequencer (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 halt,
    input  isaPkg::decodedInsn_t decoded,
    input  logic                 execDone,
    input  logic [31:0]          execResult,
    input  logic [31:0]          valZ,
    input  logic [31:0]          iData,
    input  logic [31:0]          dIn,
    output logic                 execEnable,
    output logic [31:0]          insn,
    output logic [31:0]          iAddr,
    output logic [31:0]          nextPc,
    output corePkg::dataReq_t    dataReq,
    output corePkg::regWrite_t   regWrite
);

    corePkg::seqState_t state;
    logic [31:0] execValue;     // Held execute result
    logic [31:0] loadData;
    logic [31:0] commitValue;
    logic        memOp;

    assign memOp       = decoded.isLoad || decoded.isStore;
    assign commitValue = decoded.deref ? loadData : execValue;
    assign execEnable  = (state == corePkg::DISPATCH) && !halt;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= corePkg::NEXT_PC;
            iAddr <= corePkg::RESET_VECTOR;
        end else begin
            case (state)
                corePkg::DISPATCH: begin
                    if (!halt) state <= corePkg::EXECUTE;   // Only stall point
                end
                corePkg::EXECUTE: begin
                    if (execDone) state <= corePkg::MEM_SETUP;
                end
                corePkg::MEM_SETUP:  state <= corePkg::MEM_ACCESS;
                corePkg::MEM_ACCESS: state <= corePkg::COMMIT;
                corePkg::COMMIT: begin
                    iAddr <= decoded.isBranch ? commitValue : nextPc;
                    state <= corePkg::NEXT_PC;
                end
                corePkg::NEXT_PC:    state <= corePkg::LATCH_INSN;
                default:             state <= corePkg::DISPATCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == corePkg::EXECUTE && execDone) execValue <= execResult;
        if (state == corePkg::MEM_ACCESS) loadData <= dIn;
        if (state == corePkg::NEXT_PC) nextPc <= iAddr + 32'd1;
        if (state == corePkg::LATCH_INSN) insn <= iData;
    end

    always_comb begin
        dataReq.strobe = (state == corePkg::MEM_ACCESS) && memOp;
        dataReq.write  = (state == corePkg::MEM_ACCESS) && decoded.isStore;
        dataReq.addr   = decoded.deref ? execValue : valZ;
        dataReq.wdata  = decoded.deref ? valZ : execValue;

        regWrite.en    = (state == corePkg::COMMIT) && !decoded.isStore;
        regWrite.idx   = decoded.idxZ;
        regWrite.value = commitValue;
    end

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps

module cpuCore (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              halt,
    output logic [31:0]       iAddr,
    input  logic [31:0]       iData,
    output corePkg::dataReq_t dataReq,
    input  logic [31:0]       dIn
);

    isaPkg::decodedInsn_t decoded;
    corePkg::regWrite_t   regWrite;
    logic [31:0] insn;
    logic [31:0] nextPc;
    logic [31:0] valX;
    logic [31:0] valY;
    logic [31:0] valZ;
    logic [31:0] execResult;
    logic        execEnable;
    logic        execDone;

    instrDecoder decoder_i (
        .insn    (insn),
        .decoded (decoded)
    );

    regFile regFile_i (
        .clk     (clk),
        .reset_n (reset_n),
        .idxX    (decoded.idxX),
        .idxY    (decoded.idxY),
        .idxZ    (decoded.idxZ),
        .nextPc  (nextPc),
        .write   (regWrite),
        .valX    (valX),
        .valY    (valY),
        .valZ    (valZ)
    );

    execUnit execUnit_i (
        .clk     (clk),
        .reset_n (reset_n),
        .enable  (execEnable),
        .format  (decoded.format),
        .op      (decoded.op),
        .valX    (valX),
        .valY    (valY),
        .valI    (decoded.imm),
        .done    (execDone),
        .result  (execResult)
    );

    coreSequencer sequencer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .halt       (halt),
        .decoded    (decoded),
        .execDone   (execDone),
        .execResult (execResult),
        .valZ       (valZ),
        .iData      (iData),
        .dIn        (dIn),
        .execEnable (execEnable),
        .insn       (insn),
        .iAddr      (iAddr),
        .nextPc     (nextPc),
        .dataReq    (dataReq),
        .regWrite   (regWrite)
    );

endmodule

/* cpuCore_props.sv */
`timescale 1ns/1ps

module cpuCore_props (
    input logic              clk,
    input logic              reset_n,
    input logic              execEnable,
    input logic [31:0]       iAddr,
    input corePkg::dataReq_t dataReq
);

    // Checked on the cycle right after reset as well
    assert property (@(posedge clk)
        !reset_n |=> (iAddr == corePkg::RESET_VECTOR && !dataReq.strobe
                      && !dataReq.write && !execEnable))
        else $error("core not idle at the reset vector after reset");

    assert property (@(posedge clk) disable iff (!reset_n)
        dataReq.strobe |=> !dataReq.strobe)
        else $error("data strobe held longer than one cycle");

    assert property (@(posedge clk) disable iff (!reset_n)
        dataReq.write |-> dataReq.strobe)
        else $error("data write flag without strobe");

    assert property (@(posedge clk) disable iff (!reset_n)
        execEnable |=> !execEnable)
        else $error("execute enable held longer than one cycle");

endmodule

/* execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            enable,
    input  isaPkg::format_t format,
    input  isaPkg::opcode_t op,
    input  logic [31:0]     valX,
    input  logic [31:0]     valY,
    input  logic [31:0]     valI,
    output logic            done,
    output logic [31:0]     result
);

    logic [corePkg::EXEC_LATENCY-1:0] validPipe;   // One bit per stage
    corePkg::execOperands_t routed;
    corePkg::execOperands_t operands;
    logic [31:0] opValue;
    logic [31:0] opC;          // C travels alongside stage 2
    logic [31:0] sum;

    function automatic logic [31:0] applyOp(isaPkg::opcode_t code,
                                            logic [31:0] a,
                                            logic [31:0] b);
        case (code)
            isaPkg::OP_OR:   return a | b;
            isaPkg::OP_AND:  return a & b;
            isaPkg::OP_ADD:  return a + b;
            isaPkg::OP_MUL:  return a * b;
            isaPkg::OP_PACK: return {a[19:0], b[11:0]};
            isaPkg::OP_SHL:  return a << b;
            isaPkg::OP_LT:   return {32{$signed(a) < $signed(b)}};
            isaPkg::OP_EQ:   return {32{a == b}};
            isaPkg::OP_GE:   return {32{$signed(a) >= $signed(b)}};
            isaPkg::OP_ANDN: return a & ~b;
            isaPkg::OP_XOR:  return a ^ b;
            isaPkg::OP_SUB:  return a - b;
            isaPkg::OP_ORN:  return a | ~b;
            isaPkg::OP_SHR:  return a >> b;
            isaPkg::OP_NE:   return {32{a != b}};
            default:         return $signed(a) >>> b;   // OP_SRA
        endcase
    endfunction

    always_comb begin
        case (format)
            isaPkg::FMT_XYI: routed = '{op, valX, valY, valI};
            isaPkg::FMT_XIY: routed = '{op, valX, valI, valY};
            isaPkg::FMT_IXY: routed = '{op, valI, valX, valY};
            default:         routed = '{op, 32'd0, 32'd0, valI};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[corePkg::EXEC_LATENCY-2:0], enable};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            operands <= routed;
        end
        if (validPipe[0]) begin
            opValue <= applyOp(operands.op, operands.a, operands.b);
            opC     <= operands.c;
        end
        if (validPipe[1]) begin
            sum <= opValue + opC;
        end
        if (validPipe[2]) begin
            result <= sum;
        end
    end

    assign done = validPipe[corePkg::EXEC_LATENCY-1];

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  logic [31:0]          insn,
    output isaPkg::decodedInsn_t decoded
);

    logic [11:0] shortImm;
    logic [23:0] wideImm;

    assign shortImm = insn[isaPkg::IMM_MSB:isaPkg::IMM_LSB];
    assign wideImm  = insn[isaPkg::WIDE_IMM_MSB:isaPkg::IMM_LSB];

    always_comb begin
        decoded.format  = isaPkg::format_t'(insn[isaPkg::FMT_MSB:isaPkg::FMT_LSB]);
        decoded.isStore = insn[isaPkg::STORE_BIT];
        decoded.deref   = insn[isaPkg::DEREF_BIT];
        decoded.idxZ    = insn[isaPkg::Z_MSB:isaPkg::Z_LSB];

        if (decoded.format == isaPkg::FMT_IMM) begin
            // X, Y and op fields overlap the wide immediate
            decoded.idxX = isaPkg::REG_ZERO;
            decoded.idxY = isaPkg::REG_ZERO;
            decoded.op   = isaPkg::OP_OR;              // 0 | 0 leaves C alone
            decoded.imm  = {{8{wideImm[23]}}, wideImm};
        end else begin
            decoded.idxX = insn[isaPkg::X_MSB:isaPkg::X_LSB];
            decoded.idxY = insn[isaPkg::Y_MSB:isaPkg::Y_LSB];
            decoded.op   = isaPkg::opcode_t'(insn[isaPkg::OP_MSB:isaPkg::OP_LSB]);
            decoded.imm  = {{20{shortImm[11]}}, shortImm};
        end

        decoded.isBranch = (decoded.idxZ == isaPkg::REG_PC) && !decoded.isStore;
        decoded.isLoad   = decoded.deref && !decoded.isStore;
    end

endmodule

/* isaModel.sv */
package isaModel;

    localparam int          PROG_LEN   = 200;
    localparam int          SEED_WORDS = 64;
    localparam logic [31:0] HALT_ADDR  = corePkg::RESET_VECTOR + PROG_LEN;   // Self-branch

    typedef struct packed {
        corePkg::dataReq_t req;
        logic [31:0]       nextPc;
    } prediction_t;

    logic [31:0] progMem [0:PROG_LEN];
    logic [31:0] dataSeed [0:SEED_WORDS-1];
    logic [31:0] modelMem [logic [31:0]];
    logic [31:0] regs [1:14];
    logic [31:0] pc;

    function automatic void buildProgram();
        logic [31:0] r;
        logic [1:0]  fmt;
        logic [3:0]  z;
        logic [3:0]  anyZ;
        void'($urandom(32'h7d54_33dd));
        for (int i = 0; i < PROG_LEN; i++) begin
            r    = $urandom;
            fmt  = 2'($urandom);
            z    = 4'($urandom_range(14, 0));
            anyZ = 4'($urandom);
            case ($urandom_range(7, 0))
                0: progMem[i] = (i < PROG_LEN - 1) ? 32'h4FF0_2001   // Skip next insn
                                                   : {fmt, 2'b00, z, r[23:0]};
                1: progMem[i] = {fmt, 2'b01, z, r[23:0]};            // Load
                2: progMem[i] = {fmt, 2'b11, anyZ, r[23:0]};
                3: progMem[i] = {fmt, 2'b10, anyZ, r[23:0]};
                default: progMem[i] = {fmt, 2'b00, z, r[23:0]};
            endcase
        end
        progMem[PROG_LEN] = {2'b11, 2'b00, 4'd15, HALT_ADDR[23:0]};
        for (int i = 0; i < SEED_WORDS; i++) begin
            dataSeed[i] = $urandom;
        end
        for (int i = 1; i <= 14; i++) begin
            regs[i] = '0;
        end
        modelMem.delete();
        pc = corePkg::RESET_VECTOR;
    endfunction

    function automatic logic [31:0] fetchWord(logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - corePkg::RESET_VECTOR;
        if (offset <= PROG_LEN) begin
            return progMem[offset];
        end
        return '0;
    endfunction

    function automatic logic [31:0] memDefault(logic [31:0] addr);
        if (addr < SEED_WORDS) begin
            return dataSeed[addr];
        end
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] memRead(logic [31:0] addr);
        if (modelMem.exists(addr)) begin
            return modelMem[addr];
        end
        return memDefault(addr);
    endfunction

    function automatic logic [31:0] readReg(logic [3:0] idx);
        if (idx == 4'd0) begin
            return '0;
        end
        if (idx == 4'd15) begin
            return pc + 32'd1;
        end
        return regs[idx];
    endfunction

    function automatic logic [31:0] evalOp(isaPkg::opcode_t op, logic [31:0] a,
                                           logic [31:0] b);
        case (op)
            isaPkg::OP_OR:   return a | b;
            isaPkg::OP_AND:  return a & b;
            isaPkg::OP_ADD:  return a + b;
            isaPkg::OP_MUL:  return a * b;
            isaPkg::OP_PACK: return (a << 12) | {20'd0, b[11:0]};
            isaPkg::OP_SHL:  return (b > 31) ? 32'd0 : a << b[4:0];
            isaPkg::OP_LT:   return ($signed(a) < $signed(b)) ? '1 : '0;
            isaPkg::OP_EQ:   return (a == b) ? '1 : '0;
            isaPkg::OP_GE:   return ($signed(a) >= $signed(b)) ? '1 : '0;
            isaPkg::OP_ANDN: return a & ~b;
            isaPkg::OP_XOR:  return a ^ b;
            isaPkg::OP_SUB:  return a - b;
            isaPkg::OP_ORN:  return a | ~b;
            isaPkg::OP_SHR:  return (b > 31) ? 32'd0 : a >> b[4:0];
            isaPkg::OP_NE:   return (a != b) ? '1 : '0;
            default:         return (b > 31) ? {32{a[31]}} : 32'($signed(a) >>> b[4:0]);
        endcase
    endfunction

    // Runs the instruction at pc and returns what the core must show for it
    function automatic prediction_t step();
        prediction_t     p;
        logic [31:0]     word;
        logic [31:0]     imm;
        logic [31:0]     x;
        logic [31:0]     y;
        logic [31:0]     zv;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     result;
        logic [31:0]     value;
        isaPkg::format_t fmt;
        logic [3:0]      z;
        logic            st;
        logic            dr;
        word = fetchWord(pc);
        fmt  = isaPkg::format_t'(word[isaPkg::FMT_MSB:isaPkg::FMT_LSB]);
        st   = word[isaPkg::STORE_BIT];
        dr   = word[isaPkg::DEREF_BIT];
        z    = word[isaPkg::Z_MSB:isaPkg::Z_LSB];
        x    = readReg(word[isaPkg::X_MSB:isaPkg::X_LSB]);
        y    = readReg(word[isaPkg::Y_MSB:isaPkg::Y_LSB]);
        zv   = readReg(z);
        if (fmt == isaPkg::FMT_IMM) begin
            imm = {{8{word[23]}}, word[23:0]};
        end else begin
            imm = {{20{word[11]}}, word[11:0]};
        end
        case (fmt)
            isaPkg::FMT_XYI: {a, b, c} = {x, y, imm};
            isaPkg::FMT_XIY: {a, b, c} = {x, imm, y};
            isaPkg::FMT_IXY: {a, b, c} = {imm, x, y};
            default:         {a, b, c} = {32'd0, 32'd0, imm};
        endcase
        if (fmt == isaPkg::FMT_IMM) begin
            result = c;
        end else begin
            result = evalOp(isaPkg::opcode_t'(word[isaPkg::OP_MSB:isaPkg::OP_LSB]), a, b) + c;
        end
        p.req.strobe = st || dr;
        p.req.write  = st;
        p.req.addr   = dr ? result : zv;
        p.req.wdata  = dr ? zv : result;
        p.nextPc     = pc + 32'd1;
        if (st) begin
            modelMem[p.req.addr] = p.req.wdata;
        end else begin
            value = dr ? memRead(p.req.addr) : result;
            if (z == 4'd15) begin
                p.nextPc = value;   // Branch
            end else if (z != 4'd0) begin
                regs[z] = value;
            end
        end
        pc = p.nextPc;
        return p;
    endfunction

endpackage

/* isaPkg.sv */
package isaPkg;

    // Instruction word fields
    localparam int FMT_MSB      = 31;
    localparam int FMT_LSB      = 30;
    localparam int STORE_BIT    = 29;
    localparam int DEREF_BIT    = 28;
    localparam int Z_MSB        = 27;
    localparam int Z_LSB        = 24;
    localparam int X_MSB        = 23;
    localparam int X_LSB        = 20;
    localparam int Y_MSB        = 19;
    localparam int Y_LSB        = 16;
    localparam int OP_MSB       = 15;
    localparam int OP_LSB       = 12;
    localparam int IMM_MSB      = 11;
    localparam int IMM_LSB      = 0;
    localparam int WIDE_IMM_MSB = 23;   // FMT_IMM only

    localparam logic [3:0] REG_ZERO = 4'd0;
    localparam logic [3:0] REG_PC   = 4'd15;

    // Compares yield all ones when true
    typedef enum logic [3:0] {
        OP_OR   = 4'h0,
        OP_AND  = 4'h1,
        OP_ADD  = 4'h2,
        OP_MUL  = 4'h3,
        OP_PACK = 4'h4,    // A << 12 with B[11:0]
        OP_SHL  = 4'h5,
        OP_LT   = 4'h6,
        OP_EQ   = 4'h7,
        OP_GE   = 4'h8,
        OP_ANDN = 4'h9,
        OP_XOR  = 4'hA,
        OP_SUB  = 4'hB,
        OP_ORN  = 4'hC,
        OP_SHR  = 4'hD,
        OP_NE   = 4'hE,
        OP_SRA  = 4'hF
    } opcode_t;

    typedef enum logic [1:0] {
        FMT_XYI = 2'b00,   // A=X B=Y C=I
        FMT_XIY = 2'b01,   // A=X B=I C=Y
        FMT_IXY = 2'b10,   // A=I B=X C=Y
        FMT_IMM = 2'b11    // A=B=0 C=24-bit I
    } format_t;

    typedef struct packed {
        format_t     format;
        logic        isStore;
        logic        deref;
        logic [3:0]  idxZ;
        logic [3:0]  idxX;
        logic [3:0]  idxY;
        opcode_t     op;
        logic [31:0] imm;       // Sign-extended
        logic        isBranch;
        logic        isLoad;
    } decodedInsn_t;

endpackage

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [3:0]         idxX,
    input  logic [3:0]         idxY,
    input  logic [3:0]         idxZ,
    input  logic [31:0]        nextPc,
    input  corePkg::regWrite_t write,
    output logic [31:0]        valX,
    output logic [31:0]        valY,
    output logic [31:0]        valZ
);

    logic [31:0] regs [1:14];   // R0 and PC are not stored

    function automatic logic [31:0] readPort(logic [3:0] idx);
        if (idx == isaPkg::REG_ZERO) begin
            return '0;
        end
        if (idx == isaPkg::REG_PC) begin
            return nextPc;
        end
        return regs[idx];
    endfunction

    always_comb begin
        valX = readPort(idxX);
        valY = readPort(idxY);
        valZ = readPort(idxZ);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en && write.idx != isaPkg::REG_ZERO
                     && write.idx != isaPkg::REG_PC) begin
            regs[write.idx] <= write.value;
        end
    end

endmodule

/* tb_cpuCore.sv */
`timescale 1ns/1ps

module tb_cpuCore;

    localparam int HALT_BUDGET = 4 * 31;   // Four bursts at most
    localparam int TIMEOUT     = isaModel::PROG_LEN * 10 + HALT_BUDGET + 100;

    logic              clk;
    logic              reset_n;
    logic              halt;
    logic [31:0]       iAddr;
    logic [31:0]       iData;
    logic [31:0]       dIn;
    corePkg::dataReq_t dataReq;

    logic [31:0] dutMem [logic [31:0]];
    int valueErrors = 0;
    int otherErrors = 0;
    int cycles;
    int haltLeft;
    int burstsLeft;
    bit started;
    bit finished;

    clockGen clockGen_i (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cpuCore dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .halt    (halt),
        .iAddr   (iAddr),
        .iData   (iData),
        .dataReq (dataReq),
        .dIn     (dIn)
    );

    bind cpuCore cpuCore_props props_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .execEnable (execEnable),
        .iAddr      (iAddr),
        .dataReq    (dataReq)
    );

    task automatic compareWord(string name, logic [31:0] expectedVal, logic [31:0] actual);
        assert (actual === expectedVal) else begin
            valueErrors++;
            $display("Error %s: expected %h, got %h", name, expectedVal, actual);
        end
    endtask

    task automatic reportProblem(string what);
        otherErrors++;
        $display("Problem at %0t ns: %s", $time, what);
    endtask

    function automatic logic [31:0] dutRead(logic [31:0] addr);
        if ($isunknown(addr)) begin
            return '0;
        end
        if (dutMem.exists(addr)) begin
            return dutMem[addr];
        end
        return isaModel::memDefault(addr);
    endfunction

    // Memories and halt change on the falling edge
    always @(negedge clk) begin
        iData = isaModel::fetchWord(iAddr);
        dIn   = dutRead(dataReq.addr);
        if (haltLeft > 0) begin
            halt = 1'b1;
            haltLeft--;
        end else begin
            halt = 1'b0;
            if (started && !finished && burstsLeft > 0 && $urandom_range(63, 0) == 0) begin
                haltLeft = $urandom_range(31, 12);
                burstsLeft--;
            end
        end
    end

    initial begin
        isaModel::prediction_t expected;
        logic [31:0] prevAddr;
        logic        strobeSeen;
        int          haltRun;
        bit          timedOut;
        halt       = 1'b0;
        iData      = '0;
        dIn        = '0;
        haltLeft   = 0;
        burstsLeft = 4;
        started    = 0;
        finished   = 0;
        cycles     = 0;
        haltRun    = 0;
        timedOut   = 0;
        strobeSeen = 1'b0;
        isaModel::buildProgram();
        @(posedge reset_n);
        started = 1;
        compareWord("iAddr", corePkg::RESET_VECTOR, iAddr);
        prevAddr = iAddr;
        expected = isaModel::step();
        while (!finished && !timedOut) begin
            @(posedge clk);
            cycles++;
            haltRun = halt ? haltRun + 1 : 0;
            if (dataReq.strobe) begin
                assert (cycles > 3) else reportProblem("data strobe before first dispatch");
                assert (haltRun <= 10) else reportProblem("data strobe while halted");
                assert (expected.req.strobe && !strobeSeen)
                    else reportProblem("unexpected data strobe");
                compareWord("dataReq.write", 32'(expected.req.write), 32'(dataReq.write));
                compareWord("dataReq.addr", expected.req.addr, dataReq.addr);
                if (expected.req.write) begin
                    compareWord("dataReq.wdata", expected.req.wdata, dataReq.wdata);
                end
                if (dataReq.write) begin
                    dutMem[dataReq.addr] = dataReq.wdata;
                end
                strobeSeen = 1'b1;
            end
            if (iAddr !== prevAddr) begin   // One instruction retired
                assert (haltRun <= 10) else reportProblem("fetch address moved while halted");
                assert (strobeSeen == expected.req.strobe)
                    else reportProblem("wrong number of data strobes for an instruction");
                compareWord("iAddr", expected.nextPc, iAddr);
                prevAddr   = iAddr;
                strobeSeen = 1'b0;
                if (expected.nextPc == isaModel::HALT_ADDR) begin
                    finished = 1;
                end else begin
                    expected = isaModel::step();
                end
            end
            if (cycles >= TIMEOUT) begin
                timedOut = 1;
            end
        end
        if (timedOut) begin
            $display("Timeout: program did not reach its final self-branch in %0d cycles",
                     TIMEOUT);
        end
        $display("Run ended after %0d cycles with %0d value errors and %0d other errors",
                 cycles, valueErrors, otherErrors);
        if (!timedOut && valueErrors == 0 && otherErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
